/* source/serial_dac_tx_defines.svh */
`ifndef SERIAL_DAC_TX_DEFINES_SVH
`define SERIAL_DAC_TX_DEFINES_SVH

// Number of DAC lanes
`define SDT_LANES 4

// Bits per DAC word
`define SDT_WORD_BITS 24

// Width of a lane index
`define SDT_LANE_IDX_BITS 2

`endif

/* source/serial_dac_tx_pkg.sv */
`default_nettype none

`include "serial_dac_tx_defines.svh"

package serial_dac_tx_pkg;

    typedef enum logic {
        OP_WRITE     = 1'b0,
        OP_BROADCAST = 1'b1
    } sdt_opcode_e;

    typedef enum logic [1:0] {
        LANE_IDLE  = 2'd0,
        LANE_SHIFT = 2'd1,
        LANE_DONE  = 2'd2
    } sdt_lane_state_e;

    typedef struct packed {
        logic [`SDT_WORD_BITS-1:0] data;
    } sdt_word_t;

    // Host command with the opcode in the top bit
    typedef struct packed {
        sdt_opcode_e                   opcode;
        logic [`SDT_LANE_IDX_BITS-1:0] lane;
        sdt_word_t                     word;
    } sdt_cmd_t;

    typedef struct packed {
        logic [`SDT_LANE_IDX_BITS-1:0] lane;
        logic                          overrun;
    } sdt_done_t;

endpackage

`default_nettype wire

/* source/command_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_dac_tx_defines.svh"

module command_dispatcher
    import serial_dac_tx_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire sdt_cmd_t              i_cmd,
    input  wire logic                  i_cmd_valid,
    output logic                       o_cmd_ready,
    output sdt_word_t                  o_word,
    output logic [`SDT_LANES-1:0]      o_word_valid,
    input  wire logic [`SDT_LANES-1:0] i_word_ready
);

    logic [`SDT_LANES-1:0] valid_q;
    logic [`SDT_LANES-1:0] target;
    sdt_word_t             word_q;
    logic                  cmd_take;

    // Opcode to target lanes
    always_comb begin
        target = '0;
        case (i_cmd.opcode)
            OP_BROADCAST: begin
                target = '1;
            end
            default: begin
                target[i_cmd.lane] = 1'b1;
            end
        endcase
    end

    assign cmd_take = i_cmd_valid && o_cmd_ready;

    // Each lane drops out once it has taken the word
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= '0;
        end else if (cmd_take) begin
            valid_q <= target;
        end else begin
            valid_q <= valid_q & ~i_word_ready;
        end
    end

    always_ff @(posedge i_clk) begin
        if (cmd_take) begin
            word_q <= i_cmd.word;
        end
    end

    // Hold register is free once no lane is still waiting
    assign o_cmd_ready  = (valid_q == '0);
    assign o_word       = word_q;
    assign o_word_valid = valid_q;

endmodule

`default_nettype wire

/* source/lane_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_dac_tx_defines.svh"

module lane_serializer
    import serial_dac_tx_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire logic      i_bit_en,
    input  wire sdt_word_t i_word,
    input  wire logic      i_word_valid,
    output logic           o_word_ready,
    output logic           o_dout,
    output logic           o_dout_valid,
    input  wire logic      i_link_ready,
    output logic           o_done
);

    localparam int CNT_BITS = $clog2(`SDT_WORD_BITS);
    localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(`SDT_WORD_BITS - 1);

    sdt_lane_state_e           state_q;
    sdt_lane_state_e           state_d;
    logic [`SDT_WORD_BITS-1:0] shift_q;
    logic [CNT_BITS-1:0]       count_q;
    logic                      word_take;
    logic                      bit_take;

    assign word_take = i_word_valid && (state_q == LANE_IDLE);

    // A bit leaves only when enabled and the link takes it
    assign bit_take = i_bit_en && i_link_ready && (state_q == LANE_SHIFT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            LANE_IDLE: begin
                if (word_take) begin
                    state_d = LANE_SHIFT;
                end
            end
            LANE_SHIFT: begin
                if (bit_take && (count_q == LAST_BIT)) begin
                    state_d = LANE_DONE;
                end
            end
            LANE_DONE: begin
                state_d = LANE_IDLE;
            end
            default: begin
                state_d = LANE_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= LANE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Bits sent so far in this word
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count_q <= '0;
        end else if (word_take) begin
            count_q <= '0;
        end else if (bit_take) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Shift right to send the LSB first
    always_ff @(posedge i_clk) begin
        if (word_take) begin
            shift_q <= i_word.data;
        end else if (bit_take) begin
            shift_q <= {1'b0, shift_q[`SDT_WORD_BITS-1:1]};
        end
    end

    assign o_word_ready = (state_q == LANE_IDLE);
    assign o_dout       = shift_q[0];
    assign o_dout_valid = (state_q == LANE_SHIFT);
    assign o_done       = (state_q == LANE_DONE);

endmodule

`default_nettype wire

/* source/completion_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_dac_tx_defines.svh"

module completion_arbiter
    import serial_dac_tx_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire logic [`SDT_LANES-1:0] i_lane_done,
    output sdt_done_t                  o_done,
    output logic                       o_done_valid,
    input  wire logic                  i_done_ready
);

    localparam int LANES    = `SDT_LANES;
    localparam int IDX_BITS = `SDT_LANE_IDX_BITS;

    logic [LANES-1:0]    pending_q;
    logic [LANES-1:0]    overrun_q;
    logic [LANES-1:0]    held;
    logic [LANES-1:0]    req;
    logic [LANES-1:0]    ovr_now;
    logic [LANES-1:0]    take_mask;
    logic [IDX_BITS-1:0] last_q;
    logic [IDX_BITS-1:0] grant_idx;
    logic                grant_any;
    logic                load;
    logic                valid_q;
    sdt_done_t           out_q;

    // Lane whose report still sits unacknowledged in the output register
    always_comb begin
        held = '0;
        if (valid_q && !i_done_ready) begin
            held[out_q.lane] = 1'b1;
        end
    end

    assign req     = pending_q | i_lane_done;
    assign ovr_now = overrun_q | (i_lane_done & (pending_q | held));
    assign load    = !valid_q || i_done_ready;

    // Search starts just after the last lane reported
    always_comb begin
        int unsigned cand;
        grant_any = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= LANES; k++) begin
            cand = (int'(last_q) + k) % LANES;
            if (!grant_any && req[cand]) begin
                grant_any = 1'b1;
                grant_idx = IDX_BITS'(cand);
            end
        end
    end

    assign take_mask = (load && grant_any) ? (LANES'(1) << grant_idx) : '0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending_q <= '0;
            overrun_q <= '0;
            valid_q   <= 1'b0;
            last_q    <= IDX_BITS'(LANES - 1);
        end else begin
            pending_q <= req & ~take_mask;
            overrun_q <= ovr_now & ~take_mask;
            if (load) begin
                valid_q <= grant_any;
                if (grant_any) begin
                    last_q <= grant_idx;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (load && grant_any) begin
            out_q.lane    <= grant_idx;
            out_q.overrun <= ovr_now[grant_idx];
        end
    end

    assign o_done       = out_q;
    assign o_done_valid = valid_q;

endmodule

`default_nettype wire

/* source/serial_dac_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_dac_tx_defines.svh"

module serial_dac_tx_top
    import serial_dac_tx_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire sdt_cmd_t              i_cmd,
    input  wire logic                  i_cmd_valid,
    output logic                       o_cmd_ready,
    output sdt_done_t                  o_done,
    output logic                       o_done_valid,
    input  wire logic                  i_done_ready,
    input  wire logic                  i_bit_en,
    output logic [`SDT_LANES-1:0]      o_dout,
    output logic [`SDT_LANES-1:0]      o_dout_valid,
    input  wire logic [`SDT_LANES-1:0] i_link_ready
);

    sdt_word_t             word;
    logic [`SDT_LANES-1:0] word_valid;
    logic [`SDT_LANES-1:0] word_ready;
    logic [`SDT_LANES-1:0] lane_done;

    command_dispatcher u_dispatcher (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_cmd        (i_cmd),
        .i_cmd_valid  (i_cmd_valid),
        .o_cmd_ready  (o_cmd_ready),
        .o_word       (word),
        .o_word_valid (word_valid),
        .i_word_ready (word_ready)
    );

    // One serializer per DAC lane sharing the bit enable
    for (genvar n = 0; n < `SDT_LANES; n++) begin : g_lane
        lane_serializer u_lane (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_bit_en     (i_bit_en),
            .i_word       (word),
            .i_word_valid (word_valid[n]),
            .o_word_ready (word_ready[n]),
            .o_dout       (o_dout[n]),
            .o_dout_valid (o_dout_valid[n]),
            .i_link_ready (i_link_ready[n]),
            .o_done       (lane_done[n])
        );
    end

    completion_arbiter u_arbiter (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_lane_done  (lane_done),
        .o_done       (o_done),
        .o_done_valid (o_done_valid),
        .i_done_ready (i_done_ready)
    );

endmodule

`default_nettype wire

/* dv/serial_dac_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_dac_tx_defines.svh"

module serial_dac_tx_tb
    import serial_dac_tx_pkg::*;
();

    localparam int LANES = `SDT_LANES;
    localparam int BITS  = `SDT_WORD_BITS;
    localparam int LIMIT = 4000;

    logic             clk;
    logic             rst;
    sdt_cmd_t         cmd;
    logic             cmd_valid;
    logic             cmd_ready;
    sdt_done_t        done;
    logic             done_valid;
    logic             done_ready;
    logic             bit_en;
    logic [LANES-1:0] dout;
    logic [LANES-1:0] dout_valid;
    logic [LANES-1:0] link_ready;
    logic             rand_mode;
    logic             rand_now;
    logic [31:0]      lfsr_q;
    int               errors;
    int               timeouts;
    logic [BITS-1:0]  rx_word [LANES];
    int               rx_count [LANES];
    sdt_word_t        rx_q [LANES][$];
    sdt_done_t        rep_q [$];

    serial_dac_tx_top dut (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_cmd        (cmd),
        .i_cmd_valid  (cmd_valid),
        .o_cmd_ready  (cmd_ready),
        .o_done       (done),
        .o_done_valid (done_valid),
        .i_done_ready (done_ready),
        .i_bit_en     (bit_en),
        .o_dout       (dout),
        .o_dout_valid (dout_valid),
        .i_link_ready (link_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    // Link back-pressure and bit enable redrawn every cycle
    initial begin
        lfsr_q = 32'h6111_e6a1;
        bit_en = 1'b0;
        link_ready = '0;
        rand_now = 1'b0;
        forever begin
            @(posedge clk);
            rand_now = rand_mode;
            #1;
            if (rand_now) begin
                bit_en = next_rand_bit();
                for (int n = 0; n < LANES; n++) begin
                    link_ready[n] = next_rand_bit();
                end
            end else begin
                bit_en = 1'b1;
                link_ready = '1;
            end
        end
    end

    // Link receiver where the LSB arrives first
    always @(posedge clk) begin
        if (!rst) begin
            for (int n = 0; n < LANES; n++) begin
                if (bit_en && link_ready[n] && dout_valid[n]) begin
                    rx_word[n][rx_count[n]] = dout[n];
                    if (rx_count[n] == BITS - 1) begin
                        rx_q[n].push_back(sdt_word_t'(rx_word[n]));
                        rx_count[n] = 0;
                    end else begin
                        rx_count[n]++;
                    end
                end
            end
            if (done_valid && done_ready) begin
                rep_q.push_back(done);
            end
        end
    end

    task automatic check_word(input sdt_word_t got, input sdt_word_t exp, input int lane);
        if (got !== exp) begin
            $display("ERROR @%0t: lane %0d word %h, expected %h",
                     $time, lane, got.data, exp.data);
            errors++;
        end
    endtask

    task automatic check_done(input sdt_done_t got, input sdt_done_t exp);
        if (got !== exp) begin
            $display("ERROR @%0t: report lane %0d overrun %b, expected lane %0d overrun %b",
                     $time, got.lane, got.overrun, exp.lane, exp.overrun);
            errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_cmd(input sdt_opcode_e op, input int lane, input logic [BITS-1:0] data);
        int   waited;
        logic taken;
        cmd.opcode    = op;
        cmd.lane      = `SDT_LANE_IDX_BITS'(lane);
        cmd.word.data = data;
        cmd_valid     = 1'b1;
        waited        = 0;
        taken         = 1'b0;
        while (!taken && waited < LIMIT) begin
            @(posedge clk);
            taken = cmd_ready;
            waited++;
        end
        #1;
        cmd_valid = 1'b0;
        if (!taken) begin
            $display("Timed out waiting for the command port to accept a command");
            timeouts++;
        end
    endtask

    task automatic expect_word(input int lane, input logic [BITS-1:0] data);
        int        waited;
        sdt_word_t exp;
        exp.data = data;
        waited   = 0;
        while (rx_q[lane].size() == 0 && waited < LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (rx_q[lane].size() == 0) begin
            $display("Timed out waiting for a full word on lane %0d", lane);
            timeouts++;
        end else begin
            check_word(rx_q[lane].pop_front(), exp, lane);
        end
    endtask

    task automatic wait_report(output logic ok);
        int waited;
        waited = 0;
        while (rep_q.size() == 0 && waited < LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        ok = (rep_q.size() != 0);
        if (!ok) begin
            $display("Timed out waiting for a completion report");
            timeouts++;
        end
    endtask

    task automatic expect_report(input int lane, input logic overrun);
        logic      ok;
        sdt_done_t exp;
        exp.lane    = `SDT_LANE_IDX_BITS'(lane);
        exp.overrun = overrun;
        wait_report(ok);
        if (ok) begin
            check_done(rep_q.pop_front(), exp);
        end
    endtask

    // One report per lane in any order
    task automatic expect_all_reports();
        logic      ok;
        sdt_done_t got;
        sdt_done_t exp;
        sdt_done_t slot [LANES];
        for (int k = 0; k < LANES; k++) begin
            wait_report(ok);
            if (!ok) begin
                return;
            end
            got = rep_q.pop_front();
            slot[got.lane] = got;
        end
        for (int n = 0; n < LANES; n++) begin
            exp.lane    = `SDT_LANE_IDX_BITS'(n);
            exp.overrun = 1'b0;
            check_done(slot[n], exp);
        end
    endtask

    task automatic check_lanes_quiet(input int busy_lane);
        for (int m = 0; m < LANES; m++) begin
            if (m != busy_lane) begin
                check_level(rx_q[m].size() == 0 && rx_count[m] == 0, 1'b1,
                            $sformatf("lane %0d free of stray bits", m));
            end
        end
    endtask

    task automatic test_reset_state();
        check_level(cmd_ready, 1'b1, "cmd_ready after reset");
        check_level(|dout_valid, 1'b0, "any bit valid after reset");
        check_level(done_valid, 1'b0, "done_valid after reset");
    endtask

    task automatic test_single_writes();
        logic [BITS-1:0] data;
        for (int n = 0; n < LANES; n++) begin
            data = 24'h1E_5A_C3 ^ (24'h24_9B_07 << n);
            send_cmd(OP_WRITE, n, data);
            expect_word(n, data);
            expect_report(n, 1'b0);
            check_lanes_quiet(n);
        end
    endtask

    task automatic test_broadcast(input logic [BITS-1:0] data);
        send_cmd(OP_BROADCAST, 0, data);
        for (int n = 0; n < LANES; n++) begin
            expect_word(n, data);
        end
        expect_all_reports();
    endtask

    task automatic test_random_gating();
        rand_mode = 1'b1;
        test_broadcast(24'hC0_FF_EE);
        send_cmd(OP_WRITE, 3, 24'h80_00_01);
        expect_word(3, 24'h80_00_01);
        expect_report(3, 1'b0);
        send_cmd(OP_WRITE, 1, 24'h7F_FF_FE);
        expect_word(1, 24'h7F_FF_FE);
        expect_report(1, 1'b0);
        rand_mode = 1'b0;
        check_lanes_quiet(-1);
    endtask

    task automatic test_overrun();
        sdt_done_t exp;
        done_ready = 1'b0;
        send_cmd(OP_WRITE, 2, 24'hAB_CD_EF);
        expect_word(2, 24'hAB_CD_EF);
        send_cmd(OP_WRITE, 2, 24'h12_34_56);
        expect_word(2, 24'h12_34_56);
        wait_cycles(3);
        // First report still parked with its original contents
        exp.lane    = 2'd2;
        exp.overrun = 1'b0;
        check_level(done_valid, 1'b1, "done_valid while report held");
        check_done(done, exp);
        done_ready = 1'b1;
        expect_report(2, 1'b0);
        expect_report(2, 1'b1);
        wait_cycles(3);
        check_level(done_valid, 1'b0, "done_valid after reports drained");
        check_level(rep_q.size() == 0, 1'b1, "no extra reports");
    endtask

    task automatic test_back_to_back();
        logic [BITS-1:0] data [LANES];
        for (int n = 0; n < LANES; n++) begin
            data[n] = 24'h13_57_9B + n * 24'h11_11_11;
            send_cmd(OP_WRITE, n, data[n]);
        end
        check_level(dout_valid[0], 1'b1, "lane 0 still shifting");
        for (int n = 0; n < LANES; n++) begin
            expect_word(n, data[n]);
        end
        expect_all_reports();
        check_lanes_quiet(-1);
    endtask

    initial begin
        rst        = 1'b1;
        cmd        = '0;
        cmd_valid  = 1'b0;
        done_ready = 1'b0;
        rand_mode  = 1'b0;
        errors     = 0;
        timeouts   = 0;
        for (int n = 0; n < LANES; n++) begin
            rx_count[n] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst        = 1'b0;
        done_ready = 1'b1;
        test_reset_state();
        test_single_writes();
        test_broadcast(24'h5A_A5_3C);
        test_random_gating();
        test_overrun();
        test_back_to_back();
        $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* serial_dac_tx.f */
+incdir+source
source/serial_dac_tx_pkg.sv
source/command_dispatcher.sv
source/lane_serializer.sv
source/completion_arbiter.sv
source/serial_dac_tx_top.sv
dv/serial_dac_tx_tb.sv

/* Bender.yml */
package:
  name: serial_dac_tx

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/serial_dac_tx_pkg.sv
      - source/command_dispatcher.sv
      - source/lane_serializer.sv
      - source/completion_arbiter.sv
      - source/serial_dac_tx_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/serial_dac_tx_tb.sv
